//--- logic/ritc_ctrl_defines.svh
`ifndef RITC_CTRL_DEFINES_SVH
`define RITC_CTRL_DEFINES_SVH

// Register addresses, one word each.
`define RITC_ADDR_CTRL0         4'd0
`define RITC_ADDR_CTRL1         4'd1
`define RITC_ADDR_TRAINING      4'd2
`define RITC_ADDR_COUNTER       4'd3
`define RITC_ADDR_IDELAY        4'd4
`define RITC_ADDR_SCALER        4'd5

// CTRL0 bit positions.
`define RITC_CTRL0_FIFO_RST     0
`define RITC_CTRL0_FIFO_EN      1
`define RITC_CTRL0_SERDES_RST   2
`define RITC_CTRL0_DLYCTRL_RST  3
`define RITC_CTRL0_DLYCTRL_RDY  4
`define RITC_CTRL0_DP_DISABLE   5

// TRAINING bit positions.
`define RITC_TRAIN_START        8
`define RITC_TRAIN_DONE         9
`define RITC_TRAIN_DISABLE      31

// IDELAY bit positions.
`define RITC_IDELAY_BUSY        15
`define RITC_IDELAY_BITSLIP     30
`define RITC_IDELAY_LOAD        31

// Loader frame length and count windows in clock cycles.
`define RITC_FRAME_BITS         14
`define RITC_SCALER_WINDOW      256
`define RITC_REFCLK_WINDOW      512

`endif

//--- logic/ritc_ctrl_pkg.sv
`default_nettype none

package ritc_ctrl_pkg;

	// Bus widths.
	typedef logic [3:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;

	// Delay addressing.
	typedef logic [2:0]  chan_sel_t;
	typedef logic [3:0]  bit_sel_t;
	typedef logic [4:0]  delay_tap_t;

	typedef logic [6:0]  scaler_sel_t;
	typedef logic [9:0]  refclk_cnt_t;

	// Delay or bitslip command for the serial loader.
	typedef struct packed {
		chan_sel_t  chan;
		bit_sel_t   bit_idx;
		delay_tap_t tap;
		logic       bitslip;
		logic       load;
	} delay_cmd_t;

	typedef struct packed {
		scaler_sel_t sel;
		logic        start;
	} scaler_ctrl_t;

	typedef struct packed {
		logic [2:0] sel;
		logic       restart;
	} refclk_ctrl_t;

	// Datapath levels and one-cycle pulses.
	typedef struct packed {
		logic       fifo_reset;
		logic       fifo_enable;
		logic       serdes_reset;
		logic       delayctrl_reset;
		logic       datapath_disable;
		logic       train_disable;
		logic [1:0] vcdl_pulse;
		logic [1:0] vcdl_enable;
	} dp_ctrl_t;

	typedef enum logic [0:0] {
		IDLE,
		SHIFT
	} loader_state_t;

endpackage

`default_nettype wire

//--- logic/datapath_ctrl_regs.sv
`default_nettype none

`include "ritc_ctrl_defines.svh"

module datapath_ctrl_regs (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       user_sel_i,
	input  logic                       user_wr_i,
	input  ritc_ctrl_pkg::reg_addr_t   user_addr_i,
	input  ritc_ctrl_pkg::reg_data_t   user_dat_i,
	output ritc_ctrl_pkg::reg_data_t   user_dat_o,
	input  logic                       delayctrl_ready_i,
	input  logic [5:0]                 refclk_q_i,
	input  logic                       loader_busy_i,
	input  ritc_ctrl_pkg::reg_data_t   scaler_count_i,
	input  logic                       scaler_done_i,
	input  ritc_ctrl_pkg::refclk_cnt_t refclk_count_i,
	output ritc_ctrl_pkg::dp_ctrl_t    dp_ctrl_o,
	output ritc_ctrl_pkg::delay_cmd_t  delay_cmd_o,
	output ritc_ctrl_pkg::scaler_ctrl_t scaler_ctrl_o,
	output ritc_ctrl_pkg::refclk_ctrl_t refclk_ctrl_o
);

	logic wr_en;
	logic wr_ctrl0;
	logic wr_ctrl1;
	logic wr_training;
	logic wr_counter;
	logic wr_idelay;
	logic sel_changed;

	ritc_ctrl_pkg::dp_ctrl_t     dp_q;
	ritc_ctrl_pkg::delay_cmd_t   delay_q;
	ritc_ctrl_pkg::scaler_ctrl_t scaler_q;
	ritc_ctrl_pkg::refclk_ctrl_t refclk_ctrl_q;

	ritc_ctrl_pkg::reg_addr_t rd_addr;
	ritc_ctrl_pkg::reg_data_t ctrl0_word;
	ritc_ctrl_pkg::reg_data_t ctrl1_word;
	ritc_ctrl_pkg::reg_data_t training_word;
	ritc_ctrl_pkg::reg_data_t counter_word;
	ritc_ctrl_pkg::reg_data_t idelay_word;

	// Write strobes decode the full address, so 8-15 are read-only aliases.
	assign wr_en       = user_sel_i & user_wr_i;
	assign wr_ctrl0    = wr_en & (user_addr_i == `RITC_ADDR_CTRL0);
	assign wr_ctrl1    = wr_en & (user_addr_i == `RITC_ADDR_CTRL1);
	assign wr_training = wr_en & (user_addr_i == `RITC_ADDR_TRAINING);
	assign wr_counter  = wr_en & (user_addr_i == `RITC_ADDR_COUNTER);
	assign wr_idelay   = wr_en & (user_addr_i == `RITC_ADDR_IDELAY);

	// Bit 0 of the select does not count as a change.
	assign sel_changed = (user_dat_i[6:1] != scaler_q.sel[6:1]);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			dp_q                  <= '0;
			dp_q.datapath_disable <= 1'b1;
			delay_q               <= '0;
			scaler_q              <= '0;
			refclk_ctrl_q         <= '0;
		end else begin
			// Pulses drop back after one cycle.
			dp_q.fifo_reset      <= 1'b0;
			dp_q.serdes_reset    <= 1'b0;
			dp_q.delayctrl_reset <= 1'b0;
			dp_q.vcdl_pulse      <= 2'b00;
			delay_q.load         <= 1'b0;
			delay_q.bitslip      <= 1'b0;
			scaler_q.start       <= 1'b0;
			refclk_ctrl_q.restart <= wr_counter;

			if (wr_ctrl0) begin
				dp_q.fifo_reset       <= user_dat_i[`RITC_CTRL0_FIFO_RST];
				dp_q.fifo_enable      <= user_dat_i[`RITC_CTRL0_FIFO_EN];
				dp_q.serdes_reset     <= user_dat_i[`RITC_CTRL0_SERDES_RST];
				dp_q.delayctrl_reset  <= user_dat_i[`RITC_CTRL0_DLYCTRL_RST];
				dp_q.datapath_disable <= user_dat_i[`RITC_CTRL0_DP_DISABLE];
			end

			if (wr_ctrl1) begin
				dp_q.vcdl_pulse  <= {user_dat_i[30], user_dat_i[28]};
				dp_q.vcdl_enable <= {user_dat_i[31], user_dat_i[29]};
			end

			if (wr_training) begin
				scaler_q.sel       <= user_dat_i[6:0];
				scaler_q.start     <= user_dat_i[`RITC_TRAIN_START] | sel_changed;
				dp_q.train_disable <= user_dat_i[`RITC_TRAIN_DISABLE];
			end

			if (wr_counter) begin
				refclk_ctrl_q.sel <= user_dat_i[18:16];
			end

			if (wr_idelay) begin
				delay_q.tap     <= user_dat_i[4:0];
				delay_q.bit_idx <= user_dat_i[19:16];
				delay_q.chan    <= user_dat_i[22:20];
				delay_q.bitslip <= user_dat_i[`RITC_IDELAY_BITSLIP];
				delay_q.load    <= user_dat_i[`RITC_IDELAY_LOAD];
			end
		end
	end

	// Read-back words. Pulse bits always read as zero.
	always_comb begin
		ctrl0_word                            = '0;
		ctrl0_word[`RITC_CTRL0_FIFO_EN]       = dp_q.fifo_enable;
		ctrl0_word[`RITC_CTRL0_DLYCTRL_RDY]   = delayctrl_ready_i;
		ctrl0_word[`RITC_CTRL0_DP_DISABLE]    = dp_q.datapath_disable;

		ctrl1_word        = '0;
		ctrl1_word[31]    = dp_q.vcdl_enable[1];
		ctrl1_word[29]    = dp_q.vcdl_enable[0];
		ctrl1_word[21:16] = refclk_q_i;

		training_word                        = '0;
		training_word[6:0]                   = scaler_q.sel;
		training_word[`RITC_TRAIN_DONE]      = scaler_done_i;
		training_word[`RITC_TRAIN_DISABLE]   = dp_q.train_disable;

		counter_word        = '0;
		counter_word[9:0]   = refclk_count_i;
		counter_word[18:16] = refclk_ctrl_q.sel;

		idelay_word                     = '0;
		idelay_word[4:0]                = delay_q.tap;
		idelay_word[`RITC_IDELAY_BUSY]  = loader_busy_i;
		idelay_word[22:16]              = {delay_q.chan, delay_q.bit_idx};
	end

	// Upper half of the address space mirrors the lower half.
	assign rd_addr = {1'b0, user_addr_i[2:0]};

	always_comb begin
		case (rd_addr)
			`RITC_ADDR_CTRL0:    user_dat_o = ctrl0_word;
			`RITC_ADDR_CTRL1:    user_dat_o = ctrl1_word;
			`RITC_ADDR_TRAINING: user_dat_o = training_word;
			`RITC_ADDR_COUNTER:  user_dat_o = counter_word;
			`RITC_ADDR_IDELAY:   user_dat_o = idelay_word;
			`RITC_ADDR_SCALER:   user_dat_o = scaler_count_i;
			// 6 reads TRAINING, 7 reads COUNTER.
			default:             user_dat_o = rd_addr[0] ? counter_word : training_word;
		endcase
	end

	assign dp_ctrl_o     = dp_q;
	assign delay_cmd_o   = delay_q;
	assign scaler_ctrl_o = scaler_q;
	assign refclk_ctrl_o = refclk_ctrl_q;

endmodule

`default_nettype wire

//--- logic/bit_ctrl_loader.sv
`default_nettype none

`include "ritc_ctrl_defines.svh"

module bit_ctrl_loader (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  ritc_ctrl_pkg::delay_cmd_t cmd_i,
	output logic                      busy_o,
	output logic                      ctrl_o
);

	localparam int CNT_W = $clog2(`RITC_FRAME_BITS);

	ritc_ctrl_pkg::loader_state_t state_q;
	logic [CNT_W-1:0]             cnt_q;
	logic [`RITC_FRAME_BITS-1:0]  shift_q;
	logic [`RITC_FRAME_BITS-1:0]  frame;
	logic                         accept;
	logic                         last_bit;

	// Start bit, channel, bit, tap, bitslip. Sent MSB first.
	assign frame = {1'b1, cmd_i.chan, cmd_i.bit_idx, cmd_i.tap, cmd_i.bitslip};

	// Loads arriving while shifting are dropped.
	assign accept   = (state_q == ritc_ctrl_pkg::IDLE) & cmd_i.load;
	assign last_bit = (cnt_q == CNT_W'(`RITC_FRAME_BITS - 1));

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ritc_ctrl_pkg::IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				ritc_ctrl_pkg::IDLE: begin
					if (accept) begin
						state_q <= ritc_ctrl_pkg::SHIFT;
						cnt_q   <= '0;
					end
				end
				ritc_ctrl_pkg::SHIFT: begin
					cnt_q <= cnt_q + 1'b1;
					if (last_bit) begin
						state_q <= ritc_ctrl_pkg::IDLE;
					end
				end
				default: begin
					state_q <= ritc_ctrl_pkg::IDLE;
				end
			endcase
		end
	end

	// Frame shifter.
	always_ff @(posedge clk_i) begin
		if (accept) begin
			shift_q <= frame;
		end else if (state_q == ritc_ctrl_pkg::SHIFT) begin
			shift_q <= {shift_q[`RITC_FRAME_BITS-2:0], 1'b0};
		end
	end

	assign busy_o = (state_q == ritc_ctrl_pkg::SHIFT);
	// Line idles low between frames.
	assign ctrl_o = busy_o & shift_q[`RITC_FRAME_BITS-1];

endmodule

`default_nettype wire

//--- logic/scaler_bank.sv
`default_nettype none

`include "ritc_ctrl_defines.svh"

module scaler_bank (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  ritc_ctrl_pkg::scaler_ctrl_t ctrl_i,
	input  logic [7:0]                  events_i,
	output ritc_ctrl_pkg::reg_data_t    count_o,
	output logic                        done_o
);

	localparam int GATE_W = $clog2(`RITC_SCALER_WINDOW);

	ritc_ctrl_pkg::chan_sel_t chan_q;
	ritc_ctrl_pkg::reg_data_t count_q;
	logic [GATE_W-1:0]        gate_q;
	logic                     active_q;
	logic                     done_q;
	logic                     prev_q;
	logic                     evt;
	logic                     rise;

	assign evt  = events_i[chan_q];
	assign rise = evt & ~prev_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			chan_q   <= '0;
			count_q  <= '0;
			gate_q   <= '0;
			active_q <= 1'b0;
			done_q   <= 1'b0;
			prev_q   <= 1'b0;
		end else if (ctrl_i.start) begin
			// Low three select bits pick the event input.
			chan_q   <= ctrl_i.sel[2:0];
			prev_q   <= events_i[ctrl_i.sel[2:0]];
			count_q  <= '0;
			gate_q   <= '0;
			active_q <= 1'b1;
			done_q   <= 1'b0;
		end else if (active_q) begin
			prev_q <= evt;
			gate_q <= gate_q + 1'b1;
			if (rise) begin
				count_q <= count_q + 32'd1;
			end
			// Gate closes after the last window cycle.
			if (gate_q == GATE_W'(`RITC_SCALER_WINDOW - 1)) begin
				active_q <= 1'b0;
				done_q   <= 1'b1;
			end
		end
	end

	assign count_o = count_q;
	assign done_o  = done_q;

endmodule

`default_nettype wire

//--- logic/refclk_counter.sv
`default_nettype none

`include "ritc_ctrl_defines.svh"

module refclk_counter (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  ritc_ctrl_pkg::refclk_ctrl_t ctrl_i,
	input  logic [5:0]                  refclk_q_i,
	output ritc_ctrl_pkg::refclk_cnt_t  count_o
);

	localparam int WIN_W = $clog2(`RITC_REFCLK_WINDOW);

	logic [WIN_W-1:0]           win_q;
	ritc_ctrl_pkg::refclk_cnt_t acc_q;
	ritc_ctrl_pkg::refclk_cnt_t count_q;
	logic [7:0]                 phases;
	logic                       sample;

	// Selects 6 and 7 land on tied-off phases.
	assign phases = {2'b00, refclk_q_i};
	assign sample = phases[ctrl_i.sel];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			win_q   <= '0;
			acc_q   <= '0;
			count_q <= '0;
		end else if (ctrl_i.restart) begin
			win_q <= '0;
			acc_q <= '0;
		end else begin
			// Window counter wraps on its own.
			win_q <= win_q + 1'b1;
			if (win_q == WIN_W'(`RITC_REFCLK_WINDOW - 1)) begin
				count_q <= acc_q + ritc_ctrl_pkg::refclk_cnt_t'(sample);
				acc_q   <= '0;
			end else begin
				acc_q <= acc_q + ritc_ctrl_pkg::refclk_cnt_t'(sample);
			end
		end
	end

	assign count_o = count_q;

endmodule

`default_nettype wire

//--- logic/ritc_ctrl_top.sv
`default_nettype none

module ritc_ctrl_top (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     user_sel_i,
	input  logic                     user_wr_i,
	input  ritc_ctrl_pkg::reg_addr_t user_addr_i,
	input  ritc_ctrl_pkg::reg_data_t user_dat_i,
	output ritc_ctrl_pkg::reg_data_t user_dat_o,
	input  logic                     delayctrl_ready_i,
	input  logic [5:0]               refclk_q_i,
	input  logic [7:0]               events_i,
	output ritc_ctrl_pkg::dp_ctrl_t  dp_ctrl_o,
	output logic                     ctrl_o
);

	ritc_ctrl_pkg::delay_cmd_t   delay_cmd;
	ritc_ctrl_pkg::scaler_ctrl_t scaler_ctrl;
	ritc_ctrl_pkg::refclk_ctrl_t refclk_ctrl;
	ritc_ctrl_pkg::reg_data_t    scaler_count;
	ritc_ctrl_pkg::refclk_cnt_t  refclk_count;
	logic                        loader_busy;
	logic                        scaler_done;

	datapath_ctrl_regs u_regs (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.user_sel_i        (user_sel_i),
		.user_wr_i         (user_wr_i),
		.user_addr_i       (user_addr_i),
		.user_dat_i        (user_dat_i),
		.user_dat_o        (user_dat_o),
		.delayctrl_ready_i (delayctrl_ready_i),
		.refclk_q_i        (refclk_q_i),
		.loader_busy_i     (loader_busy),
		.scaler_count_i    (scaler_count),
		.scaler_done_i     (scaler_done),
		.refclk_count_i    (refclk_count),
		.dp_ctrl_o         (dp_ctrl_o),
		.delay_cmd_o       (delay_cmd),
		.scaler_ctrl_o     (scaler_ctrl),
		.refclk_ctrl_o     (refclk_ctrl)
	);

	// Serial command line to the digitizer.
	bit_ctrl_loader u_loader (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.cmd_i   (delay_cmd),
		.busy_o  (loader_busy),
		.ctrl_o  (ctrl_o)
	);

	scaler_bank u_scaler (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.ctrl_i   (scaler_ctrl),
		.events_i (events_i),
		.count_o  (scaler_count),
		.done_o   (scaler_done)
	);

	refclk_counter u_refclk (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.ctrl_i     (refclk_ctrl),
		.refclk_q_i (refclk_q_i),
		.count_o    (refclk_count)
	);

endmodule

`default_nettype wire

//--- testbench/ritc_ctrl_tb.sv
`default_nettype none

`include "ritc_ctrl_defines.svh"

module ritc_ctrl_tb;

	localparam logic [31:0] SEED = 32'h1ec4;
	localparam int REFCLK_TESTS = 4;
	// Refclk tests dominate, two windows each, plus scaler gate and bus traffic.
	localparam int TIMEOUT_CYCLES =
		2 * (REFCLK_TESTS * 2 * `RITC_REFCLK_WINDOW + `RITC_SCALER_WINDOW + 400);

	logic                       clk_i;
	logic                       rst_n_i;
	logic                       user_sel_i;
	logic                       user_wr_i;
	ritc_ctrl_pkg::reg_addr_t   user_addr_i;
	ritc_ctrl_pkg::reg_data_t   user_dat_i;
	ritc_ctrl_pkg::reg_data_t   user_dat_o;
	logic                       delayctrl_ready_i;
	logic [5:0]                 refclk_q_i;
	logic [7:0]                 events_i;
	ritc_ctrl_pkg::dp_ctrl_t    dp_ctrl_o;
	logic                       ctrl_o;

	int          err_cnt = 0;
	int          check_cnt = 0;
	int          cycle_cnt = 0;
	string       test_name = "none";
	logic [31:0] rng_state;
	logic [31:0] evt_state;

	ritc_ctrl_top ritc_ctrl_top_i (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.user_sel_i        (user_sel_i),
		.user_wr_i         (user_wr_i),
		.user_addr_i       (user_addr_i),
		.user_dat_i        (user_dat_i),
		.user_dat_o        (user_dat_o),
		.delayctrl_ready_i (delayctrl_ready_i),
		.refclk_q_i        (refclk_q_i),
		.events_i          (events_i),
		.dp_ctrl_o         (dp_ctrl_o),
		.ctrl_o            (ctrl_o)
	);

	always #2 clk_i = ~clk_i;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Fresh random event pattern every cycle.
	always @(posedge clk_i) begin
		evt_state = next_random(evt_state);
		events_i <= evt_state[7:0];
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic write_reg(input ritc_ctrl_pkg::reg_addr_t addr,
		input ritc_ctrl_pkg::reg_data_t data);
		@(posedge clk_i);
		user_sel_i  <= 1'b1;
		user_wr_i   <= 1'b1;
		user_addr_i <= addr;
		user_dat_i  <= data;
		@(posedge clk_i);
		user_sel_i <= 1'b0;
		user_wr_i  <= 1'b0;
	endtask

	task automatic read_reg(input ritc_ctrl_pkg::reg_addr_t addr,
		output ritc_ctrl_pkg::reg_data_t data);
		@(posedge clk_i);
		user_sel_i  <= 1'b1;
		user_wr_i   <= 1'b0;
		user_addr_i <= addr;
		@(negedge clk_i);
		data = user_dat_o;
	endtask

	task automatic check_eq(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_cnt++;
		assert (actual === expected) else begin
			err_cnt++;
			$display("error %s/%s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		check_cnt++;
		assert (cond === 1'b1) else begin
			err_cnt++;
			$display("%s: %s", test_name, what);
		end
	endtask

	// Pulses {fifo, serdes, delayctrl, vcdl[1:0]}, levels {fifo_en, dp_disable, vcdl_en[1:0]}.
	task automatic check_pulse_write(input ritc_ctrl_pkg::reg_addr_t addr,
		input ritc_ctrl_pkg::reg_data_t data, input logic [4:0] exp_pulses,
		input logic [3:0] exp_levels);
		write_reg(addr, data);
		@(negedge clk_i);
		check_eq("pulses high", 32'(exp_pulses), 32'({dp_ctrl_o.fifo_reset,
			dp_ctrl_o.serdes_reset, dp_ctrl_o.delayctrl_reset, dp_ctrl_o.vcdl_pulse}));
		check_eq("levels set", 32'(exp_levels), 32'({dp_ctrl_o.fifo_enable,
			dp_ctrl_o.datapath_disable, dp_ctrl_o.vcdl_enable}));
		@(negedge clk_i);
		check_eq("pulses low", 32'h0, 32'({dp_ctrl_o.fifo_reset,
			dp_ctrl_o.serdes_reset, dp_ctrl_o.delayctrl_reset, dp_ctrl_o.vcdl_pulse}));
		check_eq("levels held", 32'(exp_levels), 32'({dp_ctrl_o.fifo_enable,
			dp_ctrl_o.datapath_disable, dp_ctrl_o.vcdl_enable}));
	endtask

	initial begin
		int                          i;
		int                          k;
		int                          pass;
		int                          tries;
		int                          highs;
		int                          model_count;
		logic [31:0]                 wdat;
		logic [31:0]                 rd;
		logic [31:0]                 rd_alias;
		logic [31:0]                 exp;
		logic [31:0]                 care;
		logic [31:0]                 cmd;
		logic [31:0]                 cmd2;
		logic [`RITC_FRAME_BITS-1:0] frame;
		logic [6:0]                  scaler_sel;
		logic [2:0]                  sel;
		logic                        prev_evt;
		logic                        cur_evt;
		ritc_ctrl_pkg::dp_ctrl_t     exp_dp;

		rng_state = SEED;
		evt_state = SEED;
		rng_state = next_random(rng_state);
		clk_i             = 1'b0;
		rst_n_i           = 1'b0;
		user_sel_i        = 1'b0;
		user_wr_i         = 1'b0;
		user_addr_i       = '0;
		user_dat_i        = '0;
		delayctrl_ready_i = 1'b1;
		events_i          = '0;
		// Held constant for the whole run.
		refclk_q_i        = rng_state[5:0];

		repeat (8) @(posedge clk_i);
		rst_n_i <= 1'b1;

		test_name = "reset";
		@(negedge clk_i);
		exp_dp = '0;
		exp_dp.datapath_disable = 1'b1;
		check_eq("dp_ctrl", 32'(exp_dp), 32'(dp_ctrl_o));
		read_reg(`RITC_ADDR_CTRL0, rd);
		check_eq("ctrl0", 32'h0000_0030, rd);
		read_reg(`RITC_ADDR_COUNTER, rd);
		check_eq("counter", 32'h0, rd);

		test_name = "readback";
		for (pass = 0; pass < 2; pass++) begin
			// Ready input differs between the two passes.
			@(posedge clk_i);
			delayctrl_ready_i <= 1'(pass);
			for (i = 0; i < 5; i++) begin
				rng_state = next_random(rng_state);
				wdat = rng_state;
				care = '1;
				case (i)
					0: exp = (wdat & 32'h0000_0022) | (32'(pass) << 4);
					1: exp = (wdat & 32'hA000_0000) | (32'(refclk_q_i) << 16);
					2: begin
						wdat[31] = (pass == 0);
						exp  = wdat & 32'h8000_007F;
						care = ~32'h0000_0200;
					end
					3: begin
						exp  = wdat & 32'h0007_0000;
						care = ~32'h0000_03FF;
					end
					default: begin
						// No load or bitslip here.
						wdat[31:30] = 2'b00;
						exp = wdat & 32'h007F_001F;
					end
				endcase
				write_reg(4'(i), wdat);
				read_reg(4'(i), rd);
				check_eq($sformatf("reg%0d", i), exp & care, rd & care);
				if (i == 2) begin
					check_eq("train_disable", 32'(wdat[31]), 32'(dp_ctrl_o.train_disable));
				end
				read_reg(4'(i) + 4'd8, rd_alias);
				check_eq($sformatf("alias%0d", i), exp & care, rd_alias & care);
			end
		end

		test_name = "pulse";
		write_reg(`RITC_ADDR_CTRL1, 32'h0);
		@(negedge clk_i);
		check_eq("idle", 32'h0, 32'({dp_ctrl_o.fifo_reset, dp_ctrl_o.serdes_reset,
			dp_ctrl_o.delayctrl_reset, dp_ctrl_o.vcdl_pulse}));
		check_pulse_write(`RITC_ADDR_CTRL0, 32'h0000_000F, 5'b11100, 4'b1000);
		check_pulse_write(`RITC_ADDR_CTRL0, 32'h0000_0021, 5'b10000, 4'b0100);
		check_pulse_write(`RITC_ADDR_CTRL1, 32'hF000_0000, 5'b00011, 4'b0111);
		check_pulse_write(`RITC_ADDR_CTRL1, 32'h1000_0000, 5'b00001, 4'b0100);
		check_pulse_write(`RITC_ADDR_CTRL1, 32'h6000_0000, 5'b00010, 4'b0101);

		test_name = "loader";
		rng_state = next_random(rng_state);
		cmd = rng_state | 32'h8000_0000;
		rng_state = next_random(rng_state);
		cmd2 = rng_state | 32'h8000_0000;
		// Start bit, channel, bit, tap, bitslip.
		frame = {1'b1, cmd[22:20], cmd[19:16], cmd[4:0], cmd[30]};
		write_reg(`RITC_ADDR_IDELAY, cmd);
		@(negedge clk_i);
		check_eq("line before frame", 32'h0, 32'(ctrl_o));
		check_eq("busy before frame", 32'h0, 32'(user_dat_o[`RITC_IDELAY_BUSY]));
		for (k = 0; k < `RITC_FRAME_BITS; k++) begin
			@(posedge clk_i);
			// Second load lands while the first frame is shifting.
			if (k == 2) begin
				user_sel_i  <= 1'b1;
				user_wr_i   <= 1'b1;
				user_addr_i <= `RITC_ADDR_IDELAY;
				user_dat_i  <= cmd2;
			end else if (k == 3) begin
				user_sel_i <= 1'b0;
				user_wr_i  <= 1'b0;
			end
			@(negedge clk_i);
			check_eq($sformatf("frame bit %0d", `RITC_FRAME_BITS - 1 - k),
				32'(frame[`RITC_FRAME_BITS-1-k]), 32'(ctrl_o));
			check_eq("busy", 32'h1, 32'(user_dat_o[`RITC_IDELAY_BUSY]));
		end
		highs = 0;
		for (k = 0; k < 2 * `RITC_FRAME_BITS + 4; k++) begin
			@(negedge clk_i);
			if (ctrl_o || user_dat_o[`RITC_IDELAY_BUSY]) begin
				highs++;
			end
		end
		check_eq("no second frame", 32'h0, 32'(highs));

		test_name = "scaler";
		rng_state = next_random(rng_state);
		scaler_sel = rng_state[6:0];
		write_reg(`RITC_ADDR_TRAINING, 32'h0000_0100 | 32'(scaler_sel));
		@(negedge clk_i);
		prev_evt = events_i[scaler_sel[2:0]];
		model_count = 0;
		for (k = 0; k < `RITC_SCALER_WINDOW; k++) begin
			@(negedge clk_i);
			cur_evt = events_i[scaler_sel[2:0]];
			if (cur_evt && !prev_evt) begin
				model_count++;
			end
			prev_evt = cur_evt;
		end
		tries = 0;
		rd = '0;
		while (!rd[`RITC_TRAIN_DONE] && tries < 16) begin
			read_reg(`RITC_ADDR_TRAINING, rd);
			tries++;
		end
		check_true(rd[`RITC_TRAIN_DONE], "done never appeared in the training register");
		check_eq("select", 32'(scaler_sel), 32'(rd[6:0]));
		read_reg(`RITC_ADDR_SCALER, rd);
		check_eq("count", 32'(model_count), rd);
		// Same select again without the start bit.
		write_reg(`RITC_ADDR_TRAINING, 32'(scaler_sel));
		read_reg(`RITC_ADDR_TRAINING, rd);
		check_true(rd[`RITC_TRAIN_DONE], "rewriting the same select restarted the scaler");
		read_reg(`RITC_ADDR_SCALER + 4'd8, rd);
		check_eq("count held", 32'(model_count), rd);

		test_name = "refclk";
		for (i = 0; i < REFCLK_TESTS; i++) begin
			rng_state = next_random(rng_state);
			if (i < REFCLK_TESTS - 2) begin
				sel = 3'(rng_state % 32'd6);
			end else begin
				sel = 3'(6 + i - (REFCLK_TESTS - 2));
			end
			exp = 32'h0;
			if (sel < 3'd6) begin
				if (refclk_q_i[sel]) begin
					exp = 32'(`RITC_REFCLK_WINDOW);
				end
			end
			write_reg(`RITC_ADDR_COUNTER, 32'(sel) << 16);
			repeat (2 * `RITC_REFCLK_WINDOW + 2) @(posedge clk_i);
			read_reg(`RITC_ADDR_COUNTER, rd);
			check_eq($sformatf("count sel %0d", sel), exp, 32'(rd[9:0]));
			check_eq($sformatf("phase sel %0d", sel), 32'(sel), 32'(rd[18:16]));
		end

		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ritc_ctrl.f
+incdir+logic
logic/ritc_ctrl_pkg.sv
logic/datapath_ctrl_regs.sv
logic/bit_ctrl_loader.sv
logic/scaler_bank.sv
logic/refclk_counter.sv
logic/ritc_ctrl_top.sv
testbench/ritc_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ritc_ctrl testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module ritc_ctrl_tb -f ritc_ctrl.f -o ritc_ctrl_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/ritc_ctrl_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
